//--- rtl/fejkon_pcie_pkg.sv
package fejkon_pcie_pkg;

  // stream word widths
  localparam int REQ_W = 128;
  localparam int CPL_W = 128;

  typedef logic [REQ_W-1:0] req_word_t;   // raw request as it comes off the stream
  typedef logic [CPL_W-1:0] cpl_word_t;   // completion word back to the host side

  // request layout
  localparam int REQ_WRITE_BIT = 0;       // 1 = write, 0 = read
  localparam int REQ_DATA_LSB  = 1;       // write data, 32 bits
  localparam int REQ_RID_LSB   = 1;       // requester id, 16 bits, reads only
  localparam int REQ_TAG_LSB   = 17;      // tag, 8 bits, reads only
  localparam int REQ_ADDR_LSB  = 33;      // dword address, 30 bits

  // completion status field
  localparam logic [2:0] CPL_STATUS_SC = 3'd0;  // successful completion
  localparam logic [2:0] CPL_STATUS_UR = 3'd1;  // unsupported request

  // Avalon-MM response codes
  localparam logic [1:0] AV_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AV_RESP_SLVERR = 2'b10;
  localparam logic [1:0] AV_RESP_DECERR = 2'b11;

  // "FEJK" in register 0
  localparam logic [31:0] BAR_ID = 32'h4645_4A4B;

endpackage

//--- rtl/stream_fifo.sv
`timescale 1ns/100ps
module stream_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     arst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // words held
  logic             wr_en;
  logic             rd_en;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];   // head word, valid once count is nonzero
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // idle or push and pop together
      endcase
    end
  end

  // a write never lands on a slot that still holds an unread word
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    (wr_en && count != '0) |-> (wr_ptr != rd_ptr)
  );

  // stalled head word must not change under the consumer
  a_out_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  );

endmodule

//--- rtl/mem_access_bridge.sv
`timescale 1ns/100ps
module mem_access_bridge (
  input  logic                       clk,
  input  logic                       arst_n,
  input  fejkon_pcie_pkg::req_word_t rq_data,
  input  logic                       rq_valid,
  output logic                       rq_ready,
  output fejkon_pcie_pkg::cpl_word_t cp_data,
  output logic                       cp_valid,
  input  logic                       cp_ready,
  output logic [31:0]                mm_address,
  output logic                       mm_read,
  output logic                       mm_write,
  output logic [31:0]                mm_writedata,
  input  logic                       mm_waitrequest,
  input  logic [31:0]                mm_readdata,
  input  logic                       mm_readdatavalid,
  input  logic                       mm_writeresponsevalid,
  input  logic [1:0]                 mm_response,
  output logic [7:0]                 wr_err_count
);
  import fejkon_pcie_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_CMD, S_RESP, S_CPL} state_t;

  state_t      state;
  logic        is_write;    // kind of the access in flight
  logic        rq_write;
  logic [29:0] rq_dw_addr;
  logic        take;
  logic [15:0] rid_q;
  logic [7:0]  tag_q;
  logic [4:0]  lo_addr_q;   // byte address bits 6:2
  logic [2:0]  status_q;
  logic [31:0] data_q;

  assign rq_write   = rq_data[REQ_WRITE_BIT];
  assign rq_dw_addr = rq_data[REQ_ADDR_LSB +: 30];
  // a read also needs room on the completion side
  assign rq_ready   = (state == S_IDLE) && (rq_write || cp_ready);
  assign take       = rq_valid && rq_ready;

  assign cp_data = {{(CPL_W - 64){1'b0}}, data_q, status_q, lo_addr_q, tag_q, rid_q};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= S_IDLE;
      is_write <= 1'b0;
      mm_read  <= 1'b0;
      mm_write <= 1'b0;
      cp_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (take) begin
            state    <= S_CMD;
            is_write <= rq_write;
            mm_read  <= !rq_write;
            mm_write <= rq_write;
          end
        end
        S_CMD: begin
          if (!mm_waitrequest) begin   // command accepted this edge
            mm_read  <= 1'b0;
            mm_write <= 1'b0;
            state    <= S_RESP;
          end
        end
        S_RESP: begin
          if (is_write && mm_writeresponsevalid) begin
            state <= S_IDLE;           // posted, nothing to send back
          end else if (!is_write && mm_readdatavalid) begin
            state    <= S_CPL;
            cp_valid <= 1'b1;
          end
        end
        S_CPL: begin
          if (cp_ready) begin
            cp_valid <= 1'b0;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      mm_address   <= {rq_dw_addr, 2'b00};
      mm_writedata <= rq_data[REQ_DATA_LSB +: 32];
      rid_q        <= rq_data[REQ_RID_LSB +: 16];
      tag_q        <= rq_data[REQ_TAG_LSB +: 8];
      lo_addr_q    <= rq_dw_addr[4:0];
    end
    if (state == S_RESP && !is_write && mm_readdatavalid) begin
      if (mm_response == AV_RESP_OKAY) begin
        status_q <= CPL_STATUS_SC;
        data_q   <= mm_readdata;
      end else begin
        status_q <= CPL_STATUS_UR;
        data_q   <= '0;               // no data on a failed read
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_err_count <= '0;
    end else if (state == S_RESP && is_write && mm_writeresponsevalid &&
                 mm_response != AV_RESP_OKAY && wr_err_count != 8'hFF) begin
      wr_err_count <= wr_err_count + 1'b1;   // saturates at 255
    end
  end

  a_rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n) !(mm_read && mm_write)
  );

  // read data only ever answers our single outstanding read
  a_rdv_expected: assert property (
    @(posedge clk) disable iff (!arst_n)
    mm_readdatavalid |-> (state == S_RESP && !is_write)
  );

endmodule

//--- rtl/csr_bank.sv
`timescale 1ns/100ps
module csr_bank #(
  parameter int NUM_REGS = 16
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] mm_address,
  input  logic        mm_read,
  input  logic        mm_write,
  input  logic [31:0] mm_writedata,
  output logic        mm_waitrequest,
  output logic [31:0] mm_readdata,
  output logic        mm_readdatavalid,
  output logic        mm_writeresponsevalid,
  output logic [1:0]  mm_response
);
  import fejkon_pcie_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  logic [31:0]      scratch [1:NUM_REGS-1];
  logic             cmd;
  logic             wait_done;   // first cycle of the command has passed
  logic             accept;
  logic             in_range;
  logic [IDX_W-1:0] idx;
  logic [31:0]      rd_word;
  logic [1:0]       rd_resp;
  logic [1:0]       wr_resp;
  logic             rd_stage;
  logic [31:0]      rd_data_s;
  logic [1:0]       rd_resp_s;
  logic [1:0]       rd_resp_q;
  logic [1:0]       wr_resp_q;

  assign cmd            = mm_read || mm_write;
  assign mm_waitrequest = cmd && !wait_done;
  assign accept         = cmd && wait_done;
  assign in_range       = (mm_address[31:2] < 30'(NUM_REGS));
  assign idx            = mm_address[2 +: IDX_W];
  assign mm_response    = mm_writeresponsevalid ? wr_resp_q : rd_resp_q;

  always_comb begin
    if (!in_range) begin
      rd_word = '0;
      rd_resp = AV_RESP_DECERR;
    end else begin
      rd_word = (idx == '0) ? BAR_ID : scratch[idx];
      rd_resp = AV_RESP_OKAY;
    end
    if (!in_range) begin
      wr_resp = AV_RESP_DECERR;
    end else if (idx == '0) begin
      wr_resp = AV_RESP_SLVERR;   // id register is read-only
    end else begin
      wr_resp = AV_RESP_OKAY;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_done             <= 1'b0;
      rd_stage              <= 1'b0;
      mm_readdatavalid      <= 1'b0;
      mm_writeresponsevalid <= 1'b0;
    end else begin
      if (accept) begin
        wait_done <= 1'b0;
      end else if (cmd) begin
        wait_done <= 1'b1;
      end
      rd_stage              <= accept && mm_read;   // two-stage read pipe
      mm_readdatavalid      <= rd_stage;
      mm_writeresponsevalid <= accept && mm_write;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && mm_read) begin
      rd_data_s <= rd_word;
      rd_resp_s <= rd_resp;
    end
    if (rd_stage) begin
      mm_readdata <= rd_data_s;
      rd_resp_q   <= rd_resp_s;
    end
    if (accept && mm_write) begin
      wr_resp_q <= wr_resp;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        scratch[i] <= '0;
      end
    end else if (accept && mm_write && in_range && idx != '0) begin
      scratch[idx] <= mm_writedata;
    end
  end

  a_no_rd_and_wr: assert property (
    @(posedge clk) disable iff (!arst_n) !(mm_read && mm_write)
  );

endmodule

//--- rtl/fejkon_pcie_bar.sv
`timescale 1ns/100ps
module fejkon_pcie_bar #(
  parameter int REQ_DEPTH = 4,
  parameter int CPL_DEPTH = 4,
  parameter int NUM_REGS  = 16
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  fejkon_pcie_pkg::req_word_t mem_access_req_data,
  input  logic                       mem_access_req_valid,
  output logic                       mem_access_req_ready,
  output fejkon_pcie_pkg::cpl_word_t mem_access_resp_data,
  output logic                       mem_access_resp_valid,
  input  logic                       mem_access_resp_ready,
  output logic [7:0]                 wr_err_count
);
  import fejkon_pcie_pkg::*;

  req_word_t   rq_data;     // request FIFO head
  logic        rq_valid;
  logic        rq_ready;
  cpl_word_t   cp_data;     // completion into cpl_fifo
  logic        cp_valid;
  logic        cp_ready;
  logic [31:0] mm_address;
  logic        mm_read;
  logic        mm_write;
  logic [31:0] mm_writedata;
  logic        mm_waitrequest;
  logic [31:0] mm_readdata;
  logic        mm_readdatavalid;
  logic        mm_writeresponsevalid;
  logic [1:0]  mm_response;

  stream_fifo #(
    .payload_t (req_word_t),
    .DEPTH     (REQ_DEPTH)
  ) req_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (mem_access_req_data),
    .in_valid  (mem_access_req_valid),
    .in_ready  (mem_access_req_ready),
    .out_data  (rq_data),
    .out_valid (rq_valid),
    .out_ready (rq_ready)
  );

  mem_access_bridge bridge0 (
    .clk                   (clk),
    .arst_n                (arst_n),
    .rq_data               (rq_data),
    .rq_valid              (rq_valid),
    .rq_ready              (rq_ready),
    .cp_data               (cp_data),
    .cp_valid              (cp_valid),
    .cp_ready              (cp_ready),
    .mm_address            (mm_address),
    .mm_read               (mm_read),
    .mm_write              (mm_write),
    .mm_writedata          (mm_writedata),
    .mm_waitrequest        (mm_waitrequest),
    .mm_readdata           (mm_readdata),
    .mm_readdatavalid      (mm_readdatavalid),
    .mm_writeresponsevalid (mm_writeresponsevalid),
    .mm_response           (mm_response),
    .wr_err_count          (wr_err_count)
  );

  csr_bank #(
    .NUM_REGS (NUM_REGS)
  ) bank0 (
    .clk                   (clk),
    .arst_n                (arst_n),
    .mm_address            (mm_address),
    .mm_read               (mm_read),
    .mm_write              (mm_write),
    .mm_writedata          (mm_writedata),
    .mm_waitrequest        (mm_waitrequest),
    .mm_readdata           (mm_readdata),
    .mm_readdatavalid      (mm_readdatavalid),
    .mm_writeresponsevalid (mm_writeresponsevalid),
    .mm_response           (mm_response)
  );

  stream_fifo #(
    .payload_t (cpl_word_t),
    .DEPTH     (CPL_DEPTH)
  ) cpl_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (cp_data),
    .in_valid  (cp_valid),
    .in_ready  (cp_ready),
    .out_data  (mem_access_resp_data),
    .out_valid (mem_access_resp_valid),
    .out_ready (mem_access_resp_ready)
  );

endmodule

//--- bench/tb_fejkon_pcie_bar.sv
`timescale 1ns/100ps
module tb_fejkon_pcie_bar;
  import fejkon_pcie_pkg::*;

  localparam int NUM_REGS = 16;
  localparam int TIMEOUT  = 2000;   // cycles allowed per wait

  logic        clk;
  logic        arst_n;
  req_word_t   mem_access_req_data;
  logic        mem_access_req_valid;
  logic        mem_access_req_ready;
  cpl_word_t   mem_access_resp_data;
  logic        mem_access_resp_valid;
  logic        mem_access_resp_ready;
  logic [7:0]  wr_err_count;

  logic [31:0] model_regs [NUM_REGS];
  cpl_word_t   exp_q [$];     // expected completions, oldest first
  cpl_word_t   exp_head;
  int          exp_count;
  logic        hs_seen;       // completion handshake at last posedge
  int          err_cnt;
  int          tests_pass;
  int          tests_fail;
  int          test_err_base;
  int          model_err;     // expected wr_err_count
  integer      seed;
  logic        bp_done;

  fejkon_pcie_bar #(
    .REQ_DEPTH (4),
    .CPL_DEPTH (4),
    .NUM_REGS  (NUM_REGS)
  ) dut0 (
    .clk                   (clk),
    .arst_n                (arst_n),
    .mem_access_req_data   (mem_access_req_data),
    .mem_access_req_valid  (mem_access_req_valid),
    .mem_access_req_ready  (mem_access_req_ready),
    .mem_access_resp_data  (mem_access_resp_data),
    .mem_access_resp_valid (mem_access_resp_valid),
    .mem_access_resp_ready (mem_access_resp_ready),
    .wr_err_count          (wr_err_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  a_reset_state: assert property (
    @(posedge clk) !arst_n |-> (!mem_access_resp_valid && mem_access_req_ready &&
                                wr_err_count == 8'd0)
  ) else begin
    $display("ERROR at %0t: outputs not in their reset state while arst_n is low", $time);
    err_cnt++;
  end

  a_cpl_expected: assert property (
    @(posedge clk) disable iff (!arst_n)
    (mem_access_resp_valid && mem_access_resp_ready) |-> (exp_count > 0)
  ) else begin
    $display("ERROR at %0t: completion delivered although none was outstanding", $time);
    err_cnt++;
  end

  a_cpl_match: assert property (
    @(posedge clk) disable iff (!arst_n)
    (mem_access_resp_valid && mem_access_resp_ready && exp_count > 0) |->
      (mem_access_resp_data == exp_head)
  ) else begin
    $display("Mismatch at %0t: mem_access_resp_data expected %h actual %h", $time,
             $sampled(exp_head), $sampled(mem_access_resp_data));
    err_cnt++;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hs_seen <= 1'b0;
    end else begin
      hs_seen <= mem_access_resp_valid && mem_access_resp_ready;
    end
  end

  always @(negedge clk) begin
    if (hs_seen && exp_q.size() > 0) begin
      exp_q.delete(0);   // head was checked at the posedge
      refresh_head();
    end
  end

  task automatic refresh_head();
    exp_count = exp_q.size();
    exp_head  = (exp_count > 0) ? exp_q[0] : '0;
  endtask

  task automatic timeout_abort(string what);
    $display("ERROR at %0t: timed out, %s", $time, what);
    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_pass, tests_fail + 1, err_cnt + 1);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic finish_test(string name);
    if (err_cnt == test_err_base) begin
      tests_pass++;
      $display("test %s: passed", name);
    end else begin
      tests_fail++;
      $display("test %s: failed with %0d error(s)", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // completion as the request layout and register rules define it
  function automatic cpl_word_t expect_cpl(logic [29:0] dw, logic [15:0] rid, logic [7:0] tag);
    cpl_word_t   c;
    logic [31:0] data;
    logic [2:0]  st;
    if (dw >= NUM_REGS) begin
      data = 32'h0;
      st   = 3'd1;          // unsupported request
    end else if (dw == 30'd0) begin
      data = 32'h4645_4A4B;
      st   = 3'd0;
    end else begin
      data = model_regs[dw[3:0]];
      st   = 3'd0;
    end
    c        = '0;
    c[15:0]  = rid;
    c[23:16] = tag;
    c[28:24] = dw[4:0];     // byte address bits 6:2
    c[31:29] = st;
    c[63:32] = data;
    return c;
  endfunction

  // called right after a falling edge; returns after the transfer
  task automatic push_request(req_word_t w);
    int cycles;
    cycles = 0;
    mem_access_req_data  = w;
    mem_access_req_valid = 1'b1;
    while (!mem_access_req_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) timeout_abort("request FIFO never accepted a request");
    end
    @(negedge clk);
    mem_access_req_valid = 1'b0;
  endtask

  task automatic send_read(logic [29:0] dw, logic [15:0] rid, logic [7:0] tag);
    req_word_t w;
    w        = '0;
    w[16:1]  = rid;
    w[24:17] = tag;
    w[62:33] = dw;
    exp_q.push_back(expect_cpl(dw, rid, tag));
    refresh_head();
    push_request(w);
  endtask

  task automatic send_write(logic [29:0] dw, logic [31:0] data);
    req_word_t w;
    w        = '0;
    w[0]     = 1'b1;
    w[32:1]  = data;
    w[62:33] = dw;
    if (dw == 30'd0 || dw >= NUM_REGS) begin
      model_err++;          // read-only or unmapped
    end else begin
      model_regs[dw[3:0]] = data;
    end
    push_request(w);
  endtask

  task automatic wait_drained(string what);
    int cycles;
    cycles = 0;
    while (exp_count > 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("ERROR at %0t: %0d completion(s) never came back in %s", $time,
                 exp_count, what);
        timeout_abort("waiting for outstanding completions");
      end
    end
  endtask

  initial begin
    logic [31:0] rnd_op;
    logic [31:0] rnd_bp;
    logic [29:0] dw;
    seed                  = 37027;
    arst_n                = 1'b0;
    mem_access_req_data   = '0;
    mem_access_req_valid  = 1'b0;
    mem_access_resp_ready = 1'b1;
    err_cnt               = 0;
    tests_pass            = 0;
    tests_fail            = 0;
    test_err_base         = 0;
    model_err             = 0;
    bp_done               = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = 32'h0;
    end
    refresh_head();

    repeat (8) @(negedge clk);
    check_value("mem_access_resp_valid", 32'd0, {31'd0, mem_access_resp_valid});
    arst_n = 1'b1;
    @(negedge clk);
    check_value("mem_access_resp_valid", 32'd0, {31'd0, mem_access_resp_valid});
    check_value("mem_access_req_ready", 32'd1, {31'd0, mem_access_req_ready});
    check_value("wr_err_count", 32'd0, {24'd0, wr_err_count});
    finish_test("reset state");

    send_read(30'd0, 16'hBEEF, 8'h5A);
    wait_drained("ID register read");
    finish_test("ID register");

    for (int i = 1; i < NUM_REGS; i++) begin
      rnd_op = $random(seed);
      send_write(30'(i), rnd_op);
    end
    for (int i = 1; i < NUM_REGS; i++) begin
      rnd_op = $random(seed);
      send_read(30'(i), rnd_op[15:0], 8'(i));
    end
    wait_drained("scratch reads");
    finish_test("scratch registers");

    send_write(30'd0, 32'hDEAD_BEEF);
    send_read(30'd0, 16'h0102, 8'h03);
    wait_drained("read-only check");
    check_value("wr_err_count", 32'(model_err), {24'd0, wr_err_count});
    finish_test("read-only register");

    send_read(30'd16, 16'h0A0B, 8'h10);
    send_read(30'h3FFF_FFFF, 16'h0C0D, 8'h11);
    send_write(30'd17, 32'h1234_5678);
    send_read(30'd5, 16'h0E0F, 8'h12);   // also flushes the write
    wait_drained("out-of-range reads");
    check_value("wr_err_count", 32'(model_err), {24'd0, wr_err_count});
    finish_test("out-of-range address");

    fork
      begin
        for (int n = 0; n < 40; n++) begin
          rnd_op = $random(seed);
          dw     = 30'(rnd_op[15:8] % 20);   // some indices past the map
          if (rnd_op[0]) begin
            send_write(dw, $random(seed));
          end else begin
            send_read(dw, rnd_op[31:16], 8'(n));
          end
        end
        send_read(30'd0, 16'h0001, 8'hFF);
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          @(negedge clk);
          rnd_bp                = $random(seed);
          mem_access_resp_ready = (rnd_bp[3:0] == 4'd0);   // mostly stalled, both FIFOs fill
        end
        mem_access_resp_ready = 1'b1;
      end
    join
    wait_drained("back-pressure run");
    check_value("wr_err_count", 32'(model_err), {24'd0, wr_err_count});
    repeat (10) @(negedge clk);   // quiet period, catches stray completions
    finish_test("back-pressure");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_pass, tests_fail, err_cnt);
    if (tests_fail == 0 && err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- fejkon_bar.f
rtl/fejkon_pcie_pkg.sv
rtl/stream_fifo.sv
rtl/mem_access_bridge.sv
rtl/csr_bank.sv
rtl/fejkon_pcie_bar.sv
bench/tb_fejkon_pcie_bar.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the BAR testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module tb_fejkon_pcie_bar \
  -f fejkon_bar.f \
  -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run reported failures, see sim.log"
  exit 1
fi

echo "run completed, log in sim.log"
exit 0
